/* exe_mem_top.f */
design/exe_pkg.sv
design/exe_alu.sv
design/mul_seq.sv
design/exe_ctrl_fsm.sv
design/wb_master.sv
design/exe_mem_top.sv
dv/wb_mem_model.sv
dv/exe_mem_tb.sv

/* dv/exe_mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_mem_tb;

  localparam int clk_period = 4;
  localparam int rounds     = 8;
  localparam int mix_count  = 40;
  // Single-cycle ops, MUL, SW/LW pairs, LB lanes, random mix
  localparam int n_instr = 13 * rounds + rounds + 2 * rounds + 4 * rounds + mix_count;

  logic              clk;
  logic              rst;
  exe_pkg::issue_t   issue;
  logic              issue_valid;
  logic              issue_ready;
  exe_pkg::retire_t  retire;
  logic              retire_valid;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  exe_pkg::addr_t    wb_adr;
  logic [3:0]        wb_sel;
  exe_pkg::word_t    wb_dat_o;
  exe_pkg::word_t    wb_dat_i;
  logic              wb_ack;

  exe_pkg::retire_t  expect_q [$];
  exe_pkg::word_t    shadow [256];
  int                accepted_cnt;
  int                retired_cnt;
  integer            seed;

  // First 13 entries retire in a single cycle
  exe_pkg::aluop_t all_ops [17] = '{
    exe_pkg::ALU_AND, exe_pkg::ALU_OR, exe_pkg::ALU_XOR, exe_pkg::ALU_NOR,
    exe_pkg::ALU_SLL, exe_pkg::ALU_SRL, exe_pkg::ALU_SRA, exe_pkg::ALU_SLT,
    exe_pkg::ALU_SLTU, exe_pkg::ALU_ADD, exe_pkg::ALU_SUB, exe_pkg::ALU_JAL,
    exe_pkg::ALU_NOP, exe_pkg::ALU_MUL, exe_pkg::ALU_LW, exe_pkg::ALU_LB,
    exe_pkg::ALU_SW
  };

  exe_mem_top #(
    .mul_step_bits (2)
  ) exe_mem_top_i (
    .clk          (clk),
    .rst          (rst),
    .issue        (issue),
    .issue_valid  (issue_valid),
    .issue_ready  (issue_ready),
    .retire       (retire),
    .retire_valid (retire_valid),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_sel       (wb_sel),
    .wb_dat_o     (wb_dat_o),
    .wb_dat_i     (wb_dat_i),
    .wb_ack       (wb_ack)
  );

  wb_mem_model #(
    .ack_seed (32'hfe2d)
  ) mem_i (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_sel   (wb_sel),
    .wb_dat_i (wb_dat_o),
    .wb_dat_o (wb_dat_i),
    .wb_ack   (wb_ack)
  );

  task automatic abort_run;
    $display("STATUS: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  // Same contents the memory model powers up with
  function automatic exe_pkg::word_t power_on_word(input logic [7:0] a);
    return {a, a ^ 8'ha5, ~a, a + 8'h3c};
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  function automatic exe_pkg::retire_t ref_exec(input exe_pkg::issue_t ins);
    exe_pkg::retire_t r;
    logic [63:0]      prod;
    exe_pkg::addr_t   ea;
    exe_pkg::word_t   mword;
    logic [7:0]       lane;
    int               sh;
    ea    = ins.reg_1 + {{16{ins.imm[15]}}, ins.imm};
    mword = shadow[ea[9:2]];
    lane  = mword[{ea[1:0], 3'b000} +: 8];
    sh    = ins.reg_1[4:0];
    prod  = {32'd0, ins.reg_1} * {32'd0, ins.reg_2};
    r.write_reg = ins.write_reg;
    r.we        = ins.we;
    case (ins.aluop)
      exe_pkg::ALU_AND:  r.data = ins.reg_1 & ins.reg_2;
      exe_pkg::ALU_OR:   r.data = ins.reg_1 | ins.reg_2;
      exe_pkg::ALU_XOR:  r.data = ins.reg_1 ^ ins.reg_2;
      exe_pkg::ALU_NOR:  r.data = ~(ins.reg_1 | ins.reg_2);
      exe_pkg::ALU_SLL:  r.data = ins.reg_2 << sh;
      exe_pkg::ALU_SRL:  r.data = ins.reg_2 >> sh;
      exe_pkg::ALU_SRA:  r.data = $signed(ins.reg_2) >>> sh;
      exe_pkg::ALU_SLT:  r.data = ($signed(ins.reg_1) < $signed(ins.reg_2)) ? 32'd1 : 32'd0;
      exe_pkg::ALU_SLTU: r.data = (ins.reg_1 < ins.reg_2) ? 32'd1 : 32'd0;
      exe_pkg::ALU_ADD:  r.data = ins.reg_1 + ins.reg_2;
      exe_pkg::ALU_SUB:  r.data = ins.reg_1 - ins.reg_2;
      exe_pkg::ALU_MUL:  r.data = prod[31:0];
      exe_pkg::ALU_JAL:  r.data = ins.link_addr;
      exe_pkg::ALU_LW:   r.data = mword;
      exe_pkg::ALU_LB:   r.data = {{24{lane[7]}}, lane};
      exe_pkg::ALU_SW: begin
        r.data = ins.reg_2;
        r.we   = 1'b0;
      end
      default:           r.data = '0;
    endcase
    return r;
  endfunction

  ////////////////////
  // Stimulus helpers
  ////////////////////

  function automatic exe_pkg::issue_t random_issue(input exe_pkg::aluop_t aop);
    exe_pkg::issue_t ins;
    logic [31:0]     rnd;
    ins.aluop     = aop;
    ins.reg_1     = $random(seed);
    ins.reg_2     = $random(seed);
    ins.link_addr = $random(seed);
    rnd           = $random(seed);
    ins.imm       = rnd[15:0];
    ins.write_reg = rnd[20:16];
    ins.we        = rnd[21] | rnd[22];
    return ins;
  endfunction

  // Base register chosen so base plus displacement lands on the target
  function automatic exe_pkg::issue_t mem_issue(input exe_pkg::aluop_t aop,
                                                input logic [7:0] widx,
                                                input logic [1:0] boff);
    exe_pkg::issue_t ins;
    logic [31:0]     rnd;
    ins       = random_issue(aop);
    rnd       = $random(seed);
    ins.imm   = {{8{rnd[7]}}, rnd[7:0]};
    ins.reg_1 = {22'd0, widx, boff} - {{16{ins.imm[15]}}, ins.imm};
    return ins;
  endfunction

  // Called on a falling edge, returns on the falling edge after the accept
  task automatic send_issue(input exe_pkg::issue_t ins);
    exe_pkg::addr_t ea;
    issue       = ins;
    issue_valid = 1'b1;
    while (!issue_ready) begin
      @(negedge clk);
    end
    expect_q.push_back(ref_exec(ins));
    ea = ins.reg_1 + {{16{ins.imm[15]}}, ins.imm};
    if (ins.aluop == exe_pkg::ALU_SW) shadow[ea[9:2]] = ins.reg_2;
    @(posedge clk);
    accepted_cnt++;
    @(negedge clk);
    issue_valid = 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin : watchdog
    int limit_cycles;
    limit_cycles = n_instr * (32 / exe_mem_top_i.mul_step_bits + 10) + 64;
    #(limit_cycles * clk_period);
    $display("timeout after %0d cycles, %0d of %0d instructions retired",
             limit_cycles, retired_cnt, n_instr);
    abort_run();
  end

  ////////////////////
  // Retire compare
  ////////////////////

  always @(negedge clk) begin : compare_retire
    exe_pkg::retire_t exp;
    if (!rst) begin
      if (retire_valid) begin
        assert (expect_q.size() != 0) else begin
          $display("retire pulse with no instruction in flight");
          abort_run();
        end
        exp = expect_q.pop_front();
        assert (retire.data == exp.data) else begin
          $display("mismatch retire.data exp=%h got=%h", exp.data, retire.data);
          abort_run();
        end
        assert (retire.write_reg == exp.write_reg) else begin
          $display("mismatch retire.write_reg exp=%h got=%h", exp.write_reg, retire.write_reg);
          abort_run();
        end
        assert (retire.we == exp.we) else begin
          $display("mismatch retire.we exp=%h got=%h", exp.we, retire.we);
          abort_run();
        end
        retired_cnt++;
      end
      // Ready again only once the last accepted instruction has retired
      if (issue_ready) begin
        assert (retired_cnt == accepted_cnt) else begin
          $display("issue_ready went high while an instruction was still in flight");
          abort_run();
        end
      end
      // Strobe moves with cycle and every access uses all four lanes
      assert (wb_stb == wb_cyc) else begin
        $display("wb_stb does not follow wb_cyc, wb_cyc=%h wb_stb=%h", wb_cyc, wb_stb);
        abort_run();
      end
      if (wb_cyc) begin
        assert (wb_sel == 4'hf) else begin
          $display("mismatch wb_sel exp=%h got=%h", 4'hf, wb_sel);
          abort_run();
        end
      end
    end
  end

  initial begin : main_flow
    exe_pkg::issue_t ins;
    logic [31:0]     rnd;
    logic [7:0]      widx;
    int              op_idx;
    seed         = 32'hfe2d;
    rst          = 1'b1;
    issue        = '0;
    issue_valid  = 1'b0;
    accepted_cnt = 0;
    retired_cnt  = 0;
    for (int i = 0; i < 256; i++) begin
      shadow[i] = power_on_word(8'(i));
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Quiet outputs before the first issue
    repeat (8) begin
      @(negedge clk);
      assert (!retire_valid && !wb_cyc && issue_ready) else begin
        $display("outputs not idle after reset, retire_valid=%h wb_cyc=%h issue_ready=%h",
                 retire_valid, wb_cyc, issue_ready);
        abort_run();
      end
    end

    // Single-cycle ops with opposite-sign operands in the first rounds
    for (int op_i = 0; op_i < 13; op_i++) begin
      for (int r = 0; r < rounds; r++) begin
        ins = random_issue(all_ops[op_i]);
        if (r == 0) begin
          ins.reg_1[31] = 1'b1;
          ins.reg_2[31] = 1'b0;
        end else if (r == 1) begin
          ins.reg_1[31] = 1'b0;
          ins.reg_2[31] = 1'b1;
        end
        send_issue(ins);
      end
    end

    for (int r = 0; r < rounds; r++) begin
      send_issue(random_issue(exe_pkg::ALU_MUL));
    end

    // Store, then load back through a different base and displacement
    for (int r = 0; r < rounds; r++) begin
      rnd    = $random(seed);
      widx   = rnd[7:0];
      ins    = mem_issue(exe_pkg::ALU_SW, widx, 2'd0);
      ins.we = 1'b1;
      send_issue(ins);
      send_issue(mem_issue(exe_pkg::ALU_LW, widx, 2'd0));
    end

    // Every byte lane of a word
    for (int r = 0; r < rounds; r++) begin
      rnd  = $random(seed);
      widx = rnd[7:0];
      for (int lane = 0; lane < 4; lane++) begin
        send_issue(mem_issue(exe_pkg::ALU_LB, widx, 2'(lane)));
      end
    end

    // Back-to-back random mix
    for (int r = 0; r < mix_count; r++) begin
      rnd    = $random(seed);
      op_idx = rnd[7:0] % 17;
      if (op_idx >= 14) begin
        ins = mem_issue(all_ops[op_idx], rnd[15:8], rnd[17:16]);
      end else begin
        ins = random_issue(all_ops[op_idx]);
      end
      send_issue(ins);
    end

    while (expect_q.size() != 0) begin
      @(negedge clk);
    end
    // Tail cycles catch any extra retire pulse
    repeat (8) @(negedge clk);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/wb_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_mem_model #(
  parameter int ack_seed = 32'hfe2d
) (
  input  wire logic           clk,
  input  wire logic           rst,
  input  wire logic           wb_cyc,
  input  wire logic           wb_stb,
  input  wire logic           wb_we,
  input  wire exe_pkg::addr_t wb_adr,
  input  wire logic [3:0]     wb_sel,
  input  wire exe_pkg::word_t wb_dat_i,
  output exe_pkg::word_t      wb_dat_o,
  output logic                wb_ack
);

  exe_pkg::word_t mem [256];
  integer         seed;
  logic [31:0]    rnd;
  logic [1:0]     wait_left;
  logic           busy;
  logic [7:0]     idx;

  assign idx = wb_adr[9:2];

  // Power-up contents, every byte a function of the word index
  function automatic exe_pkg::word_t fill_word(input logic [7:0] a);
    return {a, a ^ 8'ha5, ~a, a + 8'h3c};
  endfunction

  initial begin
    seed = ack_seed;
    for (int i = 0; i < 256; i++) begin
      mem[i] = fill_word(8'(i));
    end
  end

  // Random 0 to 3 wait cycles, ack held for one cycle
  always @(posedge clk) begin
    if (rst) begin
      wb_ack    <= 1'b0;
      busy      <= 1'b0;
      wait_left <= 2'd0;
    end else begin
      wb_ack <= 1'b0;
      if (wb_cyc && wb_stb && !wb_ack) begin
        if (!busy) begin
          rnd = $random(seed);
          busy      <= 1'b1;
          wait_left <= rnd[1:0];
        end else if (wait_left != 2'd0) begin
          wait_left <= wait_left - 2'd1;
        end else begin
          wb_ack <= 1'b1;
          busy   <= 1'b0;
          if (wb_we) begin
            for (int b = 0; b < 4; b++) begin
              if (wb_sel[b]) mem[idx][8*b +: 8] <= wb_dat_i[8*b +: 8];
            end
          end else begin
            wb_dat_o <= mem[idx];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/exe_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_mem_top #(
  parameter int mul_step_bits = 2
) (
  input  wire logic            clk,
  input  wire logic            rst,
  // Issue side
  input  wire exe_pkg::issue_t issue,
  input  wire logic            issue_valid,
  output logic                 issue_ready,
  // Retire side
  output exe_pkg::retire_t     retire,
  output logic                 retire_valid,
  // Wishbone master
  output logic                 wb_cyc,
  output logic                 wb_stb,
  output logic                 wb_we,
  output exe_pkg::addr_t       wb_adr,
  output logic [3:0]           wb_sel,
  output exe_pkg::word_t       wb_dat_o,
  input  wire exe_pkg::word_t  wb_dat_i,
  input  wire logic            wb_ack
);

  exe_pkg::issue_t   op;
  exe_pkg::word_t    alu_result;
  exe_pkg::mem_req_t mem_req;
  logic              is_mul;
  logic              is_mem;
  logic              mul_start;
  logic              mul_done;
  exe_pkg::word_t    mul_product;
  logic              bus_start;
  exe_pkg::mem_req_t bus_req;
  logic              bus_done;
  exe_pkg::word_t    load_data;

  ////////////////////
  // Datapath
  ////////////////////

  exe_alu alu_i (
    .op         (op),
    .alu_result (alu_result),
    .mem_req    (mem_req),
    .is_mul     (is_mul),
    .is_mem     (is_mem)
  );

  mul_seq #(
    .mul_step_bits (mul_step_bits)
  ) mul_i (
    .clk          (clk),
    .rst          (rst),
    .mul_start    (mul_start),
    .multiplicand (op.reg_1),
    .multiplier   (op.reg_2),
    .mul_done     (mul_done),
    .mul_product  (mul_product)
  );

  ////////////////////
  // Control and bus
  ////////////////////

  exe_ctrl_fsm ctrl_i (
    .clk          (clk),
    .rst          (rst),
    .issue        (issue),
    .issue_valid  (issue_valid),
    .is_mul       (is_mul),
    .is_mem       (is_mem),
    .alu_result   (alu_result),
    .mem_req      (mem_req),
    .mul_done     (mul_done),
    .mul_product  (mul_product),
    .bus_done     (bus_done),
    .load_data    (load_data),
    .issue_ready  (issue_ready),
    .op           (op),
    .mul_start    (mul_start),
    .bus_start    (bus_start),
    .bus_req      (bus_req),
    .retire       (retire),
    .retire_valid (retire_valid)
  );

  wb_master wb_i (
    .clk       (clk),
    .rst       (rst),
    .bus_start (bus_start),
    .bus_req   (bus_req),
    .wb_dat_i  (wb_dat_i),
    .wb_ack    (wb_ack),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_sel    (wb_sel),
    .wb_dat_o  (wb_dat_o),
    .bus_done  (bus_done),
    .load_data (load_data)
  );

endmodule

`default_nettype wire

/* design/wb_master.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_master (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              bus_start,
  input  wire exe_pkg::mem_req_t bus_req,
  input  wire exe_pkg::word_t    wb_dat_i,
  input  wire logic              wb_ack,
  output logic                   wb_cyc,
  output logic                   wb_stb,
  output logic                   wb_we,
  output exe_pkg::addr_t         wb_adr,
  output logic [3:0]             wb_sel,
  output exe_pkg::word_t         wb_dat_o,
  output logic                   bus_done,
  output exe_pkg::word_t         load_data
);

  exe_pkg::mem_op_t op_q;
  logic [1:0]       byte_lane;
  logic [7:0]       lane_byte;

  // Strobe tied to cycle in a classic cycle
  assign wb_stb   = wb_cyc;
  assign bus_done = wb_cyc && wb_ack;

  ////////////////////
  // Cycle control
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_cyc <= 1'b0;
    end else if (bus_start) begin
      wb_cyc <= 1'b1;
    end else if (bus_done) begin
      wb_cyc <= 1'b0;
    end
  end

  // Held stable until ack
  always_ff @(posedge clk) begin
    if (bus_start) begin
      wb_adr    <= {bus_req.addr[31:2], 2'b00};
      wb_we     <= (bus_req.op == exe_pkg::MEM_SW);
      wb_sel    <= 4'b1111;
      wb_dat_o  <= bus_req.data;
      op_q      <= bus_req.op;
      byte_lane <= bus_req.addr[1:0];
    end
  end

  ////////////////////
  // Load return
  ////////////////////

  // Little-endian lane pick for LB
  always_comb begin
    lane_byte = wb_dat_i[8*byte_lane +: 8];
    if (op_q == exe_pkg::MEM_LB) begin
      load_data = {{24{lane_byte[7]}}, lane_byte};
    end else begin
      load_data = wb_dat_i;
    end
  end

endmodule

`default_nettype wire

/* design/exe_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_ctrl_fsm (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire exe_pkg::issue_t   issue,
  input  wire logic              issue_valid,
  input  wire logic              is_mul,
  input  wire logic              is_mem,
  input  wire exe_pkg::word_t    alu_result,
  input  wire exe_pkg::mem_req_t mem_req,
  input  wire logic              mul_done,
  input  wire exe_pkg::word_t    mul_product,
  input  wire logic              bus_done,
  input  wire exe_pkg::word_t    load_data,
  output logic                   issue_ready,
  output exe_pkg::issue_t        op,
  output logic                   mul_start,
  output logic                   bus_start,
  output exe_pkg::mem_req_t      bus_req,
  output exe_pkg::retire_t       retire,
  output logic                   retire_valid
);

  exe_pkg::exe_state_t state;
  exe_pkg::word_t      retire_data;
  logic                retire_we;
  logic                retire_load;

  // One instruction in flight
  assign issue_ready = (state == exe_pkg::ST_IDLE);
  assign mul_start   = (state == exe_pkg::ST_RETIRE) && is_mul;

  ////////////////////
  // Retire source
  ////////////////////

  always_comb begin
    retire_data = alu_result;
    retire_we   = op.we;
    retire_load = 1'b0;
    case (state)
      exe_pkg::ST_RETIRE: retire_load = !is_mul && !is_mem;
      exe_pkg::ST_MUL: begin
        retire_data = mul_product;
        retire_load = mul_done;
      end
      exe_pkg::ST_BUS: begin
        // Stores write no register
        if (bus_req.op == exe_pkg::MEM_SW) begin
          retire_data = bus_req.data;
          retire_we   = 1'b0;
        end else begin
          retire_data = load_data;
        end
        retire_load = bus_done;
      end
      default: retire_load = 1'b0;
    endcase
  end

  ////////////////////
  // State register
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= exe_pkg::ST_IDLE;
      retire_valid <= 1'b0;
      bus_start    <= 1'b0;
    end else begin
      retire_valid <= retire_load;
      bus_start    <= 1'b0;
      case (state)
        exe_pkg::ST_IDLE: begin
          if (issue_valid) state <= exe_pkg::ST_RETIRE;
        end
        exe_pkg::ST_RETIRE: begin
          if (is_mul) begin
            state <= exe_pkg::ST_MUL;
          end else if (is_mem) begin
            state     <= exe_pkg::ST_BUS;
            bus_start <= 1'b1;
          end else begin
            state <= exe_pkg::ST_IDLE;
          end
        end
        exe_pkg::ST_MUL: if (mul_done) state <= exe_pkg::ST_IDLE;
        exe_pkg::ST_BUS: if (bus_done) state <= exe_pkg::ST_IDLE;
        default: state <= exe_pkg::ST_IDLE;
      endcase
    end
  end

  // Instruction, bus request and retire payload
  always_ff @(posedge clk) begin
    if (issue_ready && issue_valid) op <= issue;
    if ((state == exe_pkg::ST_RETIRE) && is_mem) bus_req <= mem_req;
    if (retire_load) begin
      retire.write_reg <= op.write_reg;
      retire.we        <= retire_we;
      retire.data      <= retire_data;
    end
  end

endmodule

`default_nettype wire

/* design/mul_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_seq #(
  parameter int mul_step_bits = 2
) (
  input  wire logic           clk,
  input  wire logic           rst,
  input  wire logic           mul_start,
  input  wire exe_pkg::word_t multiplicand,
  input  wire exe_pkg::word_t multiplier,
  output logic                mul_done,
  output exe_pkg::word_t      mul_product
);

  localparam int steps = 32 / mul_step_bits;
  localparam int cnt_w = $clog2(steps);

  logic [cnt_w-1:0] step_cnt;
  exe_pkg::word_t   mcand_q;
  exe_pkg::word_t   mplier_q;
  exe_pkg::word_t   acc_q;
  exe_pkg::word_t   mcand_d;
  exe_pkg::word_t   mplier_d;
  exe_pkg::word_t   acc_d;

  // First step runs straight off the operand ports
  always_comb begin
    mcand_d  = mul_start ? multiplicand : mcand_q;
    mplier_d = mul_start ? multiplier : mplier_q;
    acc_d    = mul_start ? '0 : acc_q;
    for (int i = 0; i < mul_step_bits; i++) begin
      if (mplier_d[i]) begin
        acc_d = acc_d + (mcand_d << i);
      end
    end
  end

  // Remaining steps after the start cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      step_cnt <= '0;
      mul_done <= 1'b0;
    end else if (mul_start) begin
      step_cnt <= cnt_w'(steps - 1);
      mul_done <= 1'b0;
    end else if (step_cnt != '0) begin
      step_cnt <= step_cnt - 1'b1;
      mul_done <= (step_cnt == cnt_w'(1));
    end else begin
      mul_done <= 1'b0;
    end
  end

  // Low product bits only, upper bits shift out
  always_ff @(posedge clk) begin
    if (mul_start || (step_cnt != '0)) begin
      acc_q    <= acc_d;
      mcand_q  <= mcand_d << mul_step_bits;
      mplier_q <= mplier_d >> mul_step_bits;
    end
  end

  assign mul_product = acc_q;

endmodule

`default_nettype wire

/* design/exe_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module exe_alu (
  input  wire exe_pkg::issue_t op,
  output exe_pkg::word_t       alu_result,
  output exe_pkg::mem_req_t    mem_req,
  output logic                 is_mul,
  output logic                 is_mem
);

  exe_pkg::word_t imm_ext;
  exe_pkg::addr_t eff_addr;

  // Sign-extended displacement for loads and stores
  assign imm_ext  = {{16{op.imm[15]}}, op.imm};
  assign eff_addr = op.reg_1 + imm_ext;

  ////////////////////
  // Single-cycle ops
  ////////////////////

  always_comb begin
    alu_result = '0;
    case (op.aluop)
      exe_pkg::ALU_AND:  alu_result = op.reg_1 & op.reg_2;
      exe_pkg::ALU_OR:   alu_result = op.reg_1 | op.reg_2;
      exe_pkg::ALU_XOR:  alu_result = op.reg_1 ^ op.reg_2;
      exe_pkg::ALU_NOR:  alu_result = ~(op.reg_1 | op.reg_2);
      // Shift amount always comes from reg_1
      exe_pkg::ALU_SLL:  alu_result = op.reg_2 << op.reg_1[4:0];
      exe_pkg::ALU_SRL:  alu_result = op.reg_2 >> op.reg_1[4:0];
      exe_pkg::ALU_SRA:  alu_result = $signed(op.reg_2) >>> op.reg_1[4:0];
      exe_pkg::ALU_SLT: begin
        alu_result = {31'd0, $signed(op.reg_1) < $signed(op.reg_2)};
      end
      exe_pkg::ALU_SLTU: begin
        alu_result = {31'd0, op.reg_1 < op.reg_2};
      end
      exe_pkg::ALU_ADD:  alu_result = op.reg_1 + op.reg_2;
      exe_pkg::ALU_SUB:  alu_result = op.reg_1 - op.reg_2;
      exe_pkg::ALU_JAL:  alu_result = op.link_addr;
      default:           alu_result = '0;
    endcase
  end

  ////////////////////
  // Memory requests
  ////////////////////

  always_comb begin
    mem_req.op   = exe_pkg::MEM_NOP;
    mem_req.addr = '0;
    mem_req.data = '0;
    case (op.aluop)
      exe_pkg::ALU_LW: begin
        mem_req.op   = exe_pkg::MEM_LW;
        mem_req.addr = eff_addr;
      end
      exe_pkg::ALU_LB: begin
        mem_req.op   = exe_pkg::MEM_LB;
        mem_req.addr = eff_addr;
      end
      exe_pkg::ALU_SW: begin
        mem_req.op   = exe_pkg::MEM_SW;
        mem_req.addr = eff_addr;
        mem_req.data = op.reg_2;
      end
      default: begin
        mem_req.op   = exe_pkg::MEM_NOP;
        mem_req.addr = '0;
        mem_req.data = '0;
      end
    endcase
  end

  // Multi-cycle classes that the FSM branches on
  assign is_mul = (op.aluop == exe_pkg::ALU_MUL);
  assign is_mem = (mem_req.op != exe_pkg::MEM_NOP);

endmodule

`default_nettype wire

/* design/exe_pkg.sv */
`default_nettype none

package exe_pkg;

  ////////////////////
  // Basic widths
  ////////////////////

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  reg_addr_t;

  // Execute operation codes
  typedef enum logic [5:0] {
    ALU_NOP  = 6'h00,
    ALU_AND  = 6'h01,
    ALU_OR   = 6'h02,
    ALU_XOR  = 6'h03,
    ALU_NOR  = 6'h04,
    ALU_SLL  = 6'h05,
    ALU_SRL  = 6'h06,
    ALU_SRA  = 6'h07,
    ALU_SLT  = 6'h08,
    ALU_SLTU = 6'h09,
    ALU_ADD  = 6'h0a,
    ALU_SUB  = 6'h0b,
    ALU_MUL  = 6'h0c,
    ALU_JAL  = 6'h0d,
    ALU_LW   = 6'h10,
    ALU_LB   = 6'h11,
    ALU_SW   = 6'h12
  } aluop_t;

  typedef enum logic [1:0] {
    MEM_NOP = 2'd0,
    MEM_LW  = 2'd1,
    MEM_LB  = 2'd2,
    MEM_SW  = 2'd3
  } mem_op_t;

  ////////////////////
  // Stage payloads
  ////////////////////

  // Decoded instruction as handed over by the issuer
  typedef struct packed {
    aluop_t      aluop;
    word_t       reg_1;
    word_t       reg_2;
    logic [15:0] imm;
    reg_addr_t   write_reg;
    logic        we;
    addr_t       link_addr;
  } issue_t;

  // Register write produced by one instruction
  typedef struct packed {
    reg_addr_t write_reg;
    logic      we;
    word_t     data;
  } retire_t;

  typedef struct packed {
    mem_op_t op;
    addr_t   addr;
    word_t   data;
  } mem_req_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MUL,
    ST_BUS,
    ST_RETIRE
  } exe_state_t;

endpackage

`default_nettype wire
